// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tbTop -f vlog.f -o simv

run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  memReq,
  input  wire                  memWe,
  input  wire icachePkg::wordT memAddr,
  input  wire icachePkg::wordT memWdata,
  output icachePkg::wordT      memRdata,
  output logic                 memDataOk
);

  import icachePkg::*;

  wordT       mem [4096];
  logic [3:0] beatCnt;
  logic [1:0] waitCnt;
  integer     seed;

  // tag bits 17:14, low set bits 9:6, then the beat
  function automatic logic [11:0] memIndex(wordT lineAddr, logic [3:0] beat);
    return {lineAddr[17:14], lineAddr[9:6], beat};
  endfunction

  function automatic logic [1:0] pickDelay();
    integer r;
    r = $random(seed);
    return r[1:0];
  endfunction

  initial begin
    seed = 32'hb4a68ed7;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = wordT'(i) ^ 32'h5a5a0000;
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      memDataOk <= 1'b0;
      memRdata  <= '0;
      beatCnt   <= '0;
      waitCnt   <= '0;
    end else begin
      memDataOk <= 1'b0;
      if (memReq && memDataOk) begin
        if (memWe) begin
          mem[memIndex(memAddr, beatCnt)] <= memWdata;  // write beat taken here
        end
        beatCnt <= beatCnt + 4'd1;
        waitCnt <= pickDelay();
      end else if (memReq) begin
        if (waitCnt == 2'd0) begin
          memDataOk <= 1'b1;
          memRdata  <= mem[memIndex(memAddr, beatCnt)];
        end else begin
          waitCnt <= waitCnt - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module tbTop;

  import icachePkg::*;

  localparam int RANDOM_REQS  = 200;
  localparam int NUM_REQS     = 10 + RANDOM_REQS;
  localparam int WORST_CYCLES = 80;
  localparam longint LIMIT_NS = longint'(NUM_REQS * WORST_CYCLES + 20) * 100;

  logic       clk;
  logic       rst;
  logic       req;
  logic       reqWrite;
  wordT       reqAddr;
  wordT       reqData;
  logic [3:0] reqByteEn;
  logic       memDataOk;
  wordT       memRdata;
  wordT       ins;
  logic       ok;
  logic       stall;
  logic       memReq;
  logic       memWe;
  wordT       memAddr;
  wordT       memWdata;

  wordT       refMem [4096];
  logic       seenReq;
  logic       reqStart;
  logic       expHit;
  logic       expMiss;
  logic       expWb;
  logic       curWrite;
  wordT       curAddr;
  wordT       expWord;
  wordT       wbLine;
  wordT       wbExpect;
  logic [3:0] tbBeat;
  int         readErrs;
  int         wbErrs;
  int         protoErrs;
  integer     seed;

  clkGen uClk (.clk(clk), .rst(rst));

  icacheTop i_dut (
    .clk(clk), .rst(rst), .req(req), .reqAddr(reqAddr), .reqWrite(reqWrite),
    .reqByteEn(reqByteEn), .reqData(reqData), .memDataOk(memDataOk), .memRdata(memRdata),
    .ins(ins), .ok(ok), .stall(stall), .memReq(memReq), .memWe(memWe),
    .memAddr(memAddr), .memWdata(memWdata)
  );

  memModel uMem (
    .clk(clk), .rst(rst), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
    .memWdata(memWdata), .memRdata(memRdata), .memDataOk(memDataOk)
  );

  function automatic logic [11:0] refIndex(wordT a);
    return {a[17:14], a[9:6], a[5:2]};
  endfunction

  function automatic wordT mergeBytes(wordT old, wordT nw, logic [3:0] be);
    wordT r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  function automatic wordT makeAddr(int tag, int set, int word);
    return wordT'((tag << 14) | (set << 6) | (word << 2));
  endfunction

  ////////////////////////////////////////////////////////////
  // one CPU request, held until ok
  ////////////////////////////////////////////////////////////

  task automatic access(input wordT addr, input logic wr, input logic [3:0] be,
                        input wordT data, input logic hit, input logic miss,
                        input logic wb, input wordT wbAt);
    @(posedge clk);
    req       <= 1'b1;
    reqAddr   <= addr;
    reqWrite  <= wr;
    reqByteEn <= be;
    reqData   <= data;
    reqStart  <= 1'b1;
    seenReq   <= 1'b1;
    expHit    <= hit;
    expMiss   <= miss;
    expWb     <= wb;
    wbLine    <= wbAt;
    curWrite  <= wr;
    curAddr   <= addr;
    expWord   <= refMem[refIndex(addr)];
    @(posedge clk);
    reqStart <= 1'b0;
    @(negedge clk);
    while (!ok) @(negedge clk);
    @(posedge clk);
    req <= 1'b0;
    if (wr) refMem[refIndex(addr)] = mergeBytes(refMem[refIndex(addr)], data, be);
  endtask

  // beat position inside the current burst
  always_ff @(posedge clk or posedge rst) begin
    if (rst) tbBeat <= '0;
    else if (memReq && memDataOk) tbBeat <= tbBeat + 4'd1;
  end

  always_comb wbExpect = refMem[{memAddr[17:14], memAddr[9:6], tbBeat}];

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  aQuietAfterReset: assert property (@(posedge clk) disable iff (rst)
    !seenReq |-> !(ok || stall || memReq || memWe))
  else begin
    protoErrs++;
    $display("ERROR %0t: cache active before the first request", $time);
  end

  aReadData: assert property (@(posedge clk) disable iff (rst)
    (ok && !curWrite) |-> ins == expWord)
  else begin
    readErrs++;
    $display("ERROR %0t: read of %h returned %h, expected %h", $time, curAddr, ins, expWord);
  end

  aRefillAddr: assert property (@(posedge clk) disable iff (rst)
    (memReq && !memWe) |-> memAddr == {curAddr[31:6], 6'd0})
  else begin
    protoErrs++;
    $display("ERROR %0t: refill address %h for request %h", $time, memAddr, curAddr);
  end

  aWbData: assert property (@(posedge clk) disable iff (rst)
    (memReq && memWe && memDataOk) |-> memWdata == wbExpect)
  else begin
    wbErrs++;
    $display("ERROR %0t: write-back beat %0d at %h is %h, expected %h",
             $time, tbBeat, memAddr, memWdata, wbExpect);
  end

  // stall covers every burst and drops by the ok cycle
  aStallLevel: assert property (@(posedge clk) disable iff (rst)
    !(memReq && !stall) && !(ok && stall))
  else begin
    protoErrs++;
    $display("ERROR %0t: stall %b with memReq %b and ok %b", $time, stall, memReq, ok);
  end

  aHitTiming: assert property (@(posedge clk) disable iff (rst)
    (reqStart && expHit) |=> (ok && !memReq))
  else begin
    protoErrs++;
    $display("ERROR %0t: expected hit on %h did not give ok in one cycle", $time, curAddr);
  end

  aMissStart: assert property (@(posedge clk) disable iff (rst)
    (reqStart && expMiss) |=> (!ok ##1 (memReq && !memWe)))
  else begin
    protoErrs++;
    $display("ERROR %0t: expected miss on %h did not start a burst", $time, curAddr);
  end

  aEvictStart: assert property (@(posedge clk) disable iff (rst)
    (reqStart && expWb) |=> (!ok ##1 (memReq && memWe && memAddr == wbLine)))
  else begin
    protoErrs++;
    $display("ERROR %0t: expected write-back of line %h did not start", $time, wbLine);
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired: requests did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int   tag;
    int   set;
    int   word;
    logic wr;
    wordT data;
    logic [3:0] be;
    req = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqData = '0;
    reqByteEn = '0;
    seenReq = 1'b0;
    reqStart = 1'b0;
    expHit = 1'b0;
    expMiss = 1'b0;
    expWb = 1'b0;
    curWrite = 1'b0;
    curAddr = '0;
    expWord = '0;
    wbLine = '0;
    readErrs = 0;
    wbErrs = 0;
    protoErrs = 0;
    seed = 32'hb4a68ed7;
    for (int i = 0; i < 4096; i++) refMem[i] = wordT'(i) ^ 32'h5a5a0000;
    @(negedge rst);
    repeat (3) @(posedge clk);

    access(makeAddr(0, 1, 3), 1'b0, 4'h0, '0, 1'b0, 1'b1, 1'b0, '0);  // cold miss
    access(makeAddr(0, 1, 7), 1'b0, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);
    access(makeAddr(0, 1, 9), 1'b1, 4'b0101, 32'hdeadbeef, 1'b1, 1'b0, 1'b0, '0);
    access(makeAddr(0, 1, 9), 1'b0, 4'h0, '0, 1'b1, 1'b0, 1'b0, '0);

    // fill set 5, then evict the oldest (dirty) way
    access(makeAddr(1, 5, 2), 1'b1, 4'b1111, 32'h12345678, 1'b0, 1'b1, 1'b0, '0);
    for (int t = 2; t <= 4; t++) begin
      access(makeAddr(t, 5, 0), 1'b0, 4'h0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    access(makeAddr(5, 5, 1), 1'b0, 4'h0, '0, 1'b0, 1'b0, 1'b1, makeAddr(1, 5, 0));
    access(makeAddr(1, 5, 2), 1'b0, 4'h0, '0, 1'b0, 1'b1, 1'b0, '0);

    for (int i = 0; i < RANDOM_REQS; i++) begin
      tag  = int'($unsigned($random(seed)) % 6);
      set  = 1 + int'($unsigned($random(seed)) % 3);
      word = int'($unsigned($random(seed)) % 16);
      wr   = $random(seed) & 1;
      data = $random(seed);
      be   = $random(seed) & 15;
      access(makeAddr(tag, set, word), wr, be, data, 1'b0, 1'b0, 1'b0, '0);
    end

    repeat (3) @(posedge clk);
    $display("errors: read %0d, write-back %0d, protocol %0d", readErrs, wbErrs, protoErrs);
    if (readErrs + wbErrs + protoErrs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/cacheWay.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module cacheWay #(
  parameter int WAY_ID = 0
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire icachePkg::indexT  curIndex,
  input  wire icachePkg::tagT    curTag,
  input  wire icachePkg::offsetT wordSel,
  input  wire                    wayPick,
  input  wire                    wrWordEn,
  input  wire [3:0]              wrByteEn,
  input  wire icachePkg::wordT   wrData,
  input  wire                    fillEn,
  input  wire icachePkg::wordT   fillLine [`LINE_WORDS],
  output logic                   hit,
  output logic                   valid,
  output logic                   dirty,
  output icachePkg::tagT         storedTag,
  output icachePkg::wordT        rdWord
);

  import icachePkg::*;

  tagT              tagMem  [`SETS];
  wordT             dataMem [`SETS][`LINE_WORDS];
  logic [`SETS-1:0] validBits;
  logic [`SETS-1:0] dirtyBits;

  // lookup is purely combinational
  assign storedTag = tagMem[curIndex];
  assign valid     = validBits[curIndex];
  assign dirty     = dirtyBits[curIndex];
  assign hit       = valid && (storedTag == curTag);
  assign rdWord    = dataMem[curIndex][wordSel];

  // line state bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (wayPick) begin
      if (fillEn) begin
        validBits[curIndex] <= 1'b1;
        dirtyBits[curIndex] <= 1'b0;  // fresh line from memory
      end else if (wrWordEn) begin
        dirtyBits[curIndex] <= 1'b1;
      end
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (wayPick && fillEn) begin
      tagMem[curIndex] <= curTag;
      for (int w = 0; w < `LINE_WORDS; w++) begin
        dataMem[curIndex][w] <= fillLine[w];
      end
    end else if (wayPick && wrWordEn) begin
      for (int b = 0; b < 4; b++) begin
        if (wrByteEn[b]) begin
          dataMem[curIndex][wordSel][8*b +: 8] <= wrData[8*b +: 8];  // byte merge
        end
      end
    end
  end

  // controller never merges a word while filling a line
  aNoWriteDuringFill: assert property (
    @(posedge clk) disable iff (rst) !(wrWordEn && fillEn)
  ) else $error("way %0d: word write and line fill in the same cycle", WAY_ID);

endmodule

`default_nettype wire

// File: src/icachePkg.sv
`default_nettype none

`include "icache_params.svh"

package icachePkg;

  typedef logic [`WORD_W-1:0]   wordT;
  typedef logic [`TAG_W-1:0]    tagT;
  typedef logic [`INDEX_W-1:0]  indexT;
  typedef logic [`OFFSET_W-1:0] offsetT;  // word in line, also beat count

  typedef logic [1:0] ageT;  // 0 newest, 3 oldest
  typedef logic [1:0] wayT;

  typedef enum logic [2:0] {
    sIdle,
    sLookup,
    sWriteBack,
    sRefill,
    sFill
  } cacheState;

endpackage

`default_nettype wire

// File: src/icacheTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icacheTop (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  req,
  input  wire icachePkg::wordT reqAddr,
  input  wire                  reqWrite,
  input  wire [3:0]            reqByteEn,
  input  wire icachePkg::wordT reqData,
  input  wire                  memDataOk,
  input  wire icachePkg::wordT memRdata,
  output icachePkg::wordT      ins,
  output logic                 ok,
  output logic                 stall,
  output logic                 memReq,
  output logic                 memWe,
  output icachePkg::wordT      memAddr,
  output icachePkg::wordT      memWdata
);

  import icachePkg::*;

  indexT            curIndex;
  tagT              curTag;
  offsetT           wordSel;
  logic [`WAYS-1:0] wayPick;
  logic             wrWordEn;
  logic [3:0]       wrByteEn;
  wordT             wrData;
  logic             fillEn;
  wordT             fillLine [`LINE_WORDS];
  logic             touchEn;
  wayT              touchWay;
  wayT              victimWay;
  tagT              victimTag;
  wordT             victimWord;

  logic [`WAYS-1:0] hitVec;
  logic [`WAYS-1:0] validVec;
  logic [`WAYS-1:0] dirtyVec;
  tagT              storedTag [`WAYS];
  wordT             rdWord    [`WAYS];

  ////////////////////////////////////////////////////////////
  // ways
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `WAYS; g++) begin : gWay
    cacheWay #(
      .WAY_ID (g)
    ) uWay (
      .clk       (clk),
      .rst       (rst),
      .curIndex  (curIndex),
      .curTag    (curTag),
      .wordSel   (wordSel),
      .wayPick   (wayPick[g]),
      .wrWordEn  (wrWordEn),
      .wrByteEn  (wrByteEn),
      .wrData    (wrData),
      .fillEn    (fillEn),
      .fillLine  (fillLine),
      .hit       (hitVec[g]),
      .valid     (validVec[g]),
      .dirty     (dirtyVec[g]),
      .storedTag (storedTag[g]),
      .rdWord    (rdWord[g])
    );
  end

  // read word from the hitting way, victim from the picked one
  always_comb begin
    ins        = '0;
    victimTag  = storedTag[0];
    victimWord = rdWord[0];
    for (int w = 0; w < `WAYS; w++) begin
      if (hitVec[w]) ins = rdWord[w];
      if (wayPick[w]) begin
        victimTag  = storedTag[w];
        victimWord = rdWord[w];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // replacement and control
  ////////////////////////////////////////////////////////////

  lruAges uAges (
    .clk       (clk),
    .rst       (rst),
    .curIndex  (curIndex),
    .validVec  (validVec),
    .touchEn   (touchEn),
    .touchWay  (touchWay),
    .victimWay (victimWay)
  );

  missControl uCtrl (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .reqWrite   (reqWrite),
    .reqAddr    (reqAddr),
    .reqByteEn  (reqByteEn),
    .reqData    (reqData),
    .hitVec     (hitVec),
    .dirtyVec   (dirtyVec),
    .victimTag  (victimTag),
    .victimWord (victimWord),
    .victimWay  (victimWay),
    .memDataOk  (memDataOk),
    .memRdata   (memRdata),
    .curIndex   (curIndex),
    .curTag     (curTag),
    .wordSel    (wordSel),
    .wayPick    (wayPick),
    .wrWordEn   (wrWordEn),
    .wrByteEn   (wrByteEn),
    .wrData     (wrData),
    .fillEn     (fillEn),
    .fillLine   (fillLine),
    .touchEn    (touchEn),
    .touchWay   (touchWay),
    .ok         (ok),
    .stall      (stall),
    .memReq     (memReq),
    .memWe      (memWe),
    .memAddr    (memAddr),
    .memWdata   (memWdata)
  );

endmodule

`default_nettype wire

// File: src/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////

`define WAYS        4
`define SETS        256
`define LINE_WORDS  16

// address split: tag | index | word offset | byte offset
`define TAG_W       18
`define INDEX_W     8
`define OFFSET_W    4

`define WORD_W      32

`endif

// File: src/lruAges.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module lruAges (
  input  wire                   clk,
  input  wire                   rst,
  input  wire icachePkg::indexT curIndex,
  input  wire [`WAYS-1:0]       validVec,
  input  wire                   touchEn,
  input  wire icachePkg::wayT   touchWay,
  output icachePkg::wayT        victimWay
);

  import icachePkg::*;

  ageT ages   [`SETS][`WAYS];
  ageT curAge [`WAYS];
  ageT bestAge;

  always_comb begin
    for (int w = 0; w < `WAYS; w++) begin
      curAge[w] = ages[curIndex][w];
    end
  end

  ////////////////////////////////////////////////////////////
  // age update on touch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int s = 0; s < `SETS; s++) begin
        for (int w = 0; w < `WAYS; w++) begin
          ages[s][w] <= '0;
        end
      end
    end else if (touchEn) begin
      for (int w = 0; w < `WAYS; w++) begin
        if (w == int'(touchWay)) begin
          ages[curIndex][w] <= '0;
        end else if (curAge[w] <= curAge[touchWay] && curAge[w] != 2'd3) begin
          ages[curIndex][w] <= curAge[w] + 2'd1;  // saturates at 3
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // victim choice
  ////////////////////////////////////////////////////////////

  always_comb begin
    victimWay = '0;
    bestAge   = curAge[0];
    // oldest way, lowest number on a tie
    for (int w = 1; w < `WAYS; w++) begin
      if (curAge[w] > bestAge) begin
        bestAge   = curAge[w];
        victimWay = wayT'(w);
      end
    end
    // an empty way always wins
    for (int w = `WAYS - 1; w >= 0; w--) begin
      if (!validVec[w]) begin
        victimWay = wayT'(w);
      end
    end
  end

endmodule

`default_nettype wire

// File: src/missControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module missControl (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    req,
  input  wire                    reqWrite,
  input  wire icachePkg::wordT   reqAddr,
  input  wire [3:0]              reqByteEn,
  input  wire icachePkg::wordT   reqData,
  input  wire [`WAYS-1:0]        hitVec,
  input  wire [`WAYS-1:0]        dirtyVec,
  input  wire icachePkg::tagT    victimTag,
  input  wire icachePkg::wordT   victimWord,
  input  wire icachePkg::wayT    victimWay,
  input  wire                    memDataOk,
  input  wire icachePkg::wordT   memRdata,
  output icachePkg::indexT       curIndex,
  output icachePkg::tagT         curTag,
  output icachePkg::offsetT      wordSel,
  output logic [`WAYS-1:0]       wayPick,
  output logic                   wrWordEn,
  output logic [3:0]             wrByteEn,
  output icachePkg::wordT        wrData,
  output logic                   fillEn,
  output icachePkg::wordT        fillLine [`LINE_WORDS],
  output logic                   touchEn,
  output icachePkg::wayT         touchWay,
  output logic                   ok,
  output logic                   stall,
  output logic                   memReq,
  output logic                   memWe,
  output icachePkg::wordT        memAddr,
  output icachePkg::wordT        memWdata
);

  import icachePkg::*;

  cacheState  state;
  cacheState  nextState;
  wordT       addrR;
  logic       writeR;
  logic [3:0] byteEnR;
  wordT       dataR;
  wayT        pickWay;
  offsetT     beatCnt;
  wordT       lineBuf [`LINE_WORDS];
  wayT        hitWay;
  logic       anyHit;
  logic       beat;
  logic       lastBeat;

  ////////////////////////////////////////////////////////////
  // address fields and lookup results
  ////////////////////////////////////////////////////////////

  assign curTag   = addrR[`WORD_W-1 -: `TAG_W];
  assign curIndex = addrR[`OFFSET_W+2 +: `INDEX_W];
  assign wordSel  = (state == sWriteBack) ? beatCnt : addrR[2 +: `OFFSET_W];

  assign anyHit   = |hitVec;
  assign beat     = memReq && memDataOk;
  assign lastBeat = beat && (beatCnt == offsetT'(`LINE_WORDS - 1));

  always_comb begin
    hitWay = '0;
    for (int w = 0; w < `WAYS; w++) begin
      if (hitVec[w]) begin
        hitWay = wayT'(w);
      end
    end
  end

  // way side
  assign wayPick  = (state == sLookup) ? hitVec : (`WAYS'(1) << pickWay);
  assign ok       = (state == sLookup) && anyHit;
  assign touchEn  = ok;
  assign touchWay = hitWay;
  assign wrWordEn = ok && writeR;  // write lands with ok
  assign wrByteEn = byteEnR;
  assign wrData   = dataR;
  assign fillEn   = (state == sFill);
  assign fillLine = lineBuf;
  assign stall    = state inside {sWriteBack, sRefill, sFill};

  // memory side
  assign memWe    = memReq && (state == sWriteBack);
  assign memAddr  = {(state == sWriteBack) ? victimTag : curTag, curIndex,
                     {(`OFFSET_W + 2){1'b0}}};
  assign memWdata = victimWord;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (req) nextState = sLookup;
      end
      sLookup: begin
        if (anyHit) nextState = sIdle;
        else if (dirtyVec[victimWay]) nextState = sWriteBack;
        else nextState = sRefill;
      end
      sWriteBack: begin
        if (lastBeat) nextState = sRefill;
      end
      sRefill: begin
        if (lastBeat) nextState = sFill;
      end
      sFill: nextState = sLookup;  // retry now hits
      default: nextState = sIdle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= sIdle;
      writeR  <= 1'b0;
      pickWay <= '0;
      beatCnt <= '0;
      memReq  <= 1'b0;
    end else begin
      state <= nextState;
      if (state == sIdle && req) writeR <= reqWrite;
      if (state == sLookup && !anyHit) pickWay <= victimWay;
      if (beat) beatCnt <= offsetT'(beatCnt + 1'b1);  // wraps after beat 16
      // one idle cycle between write-back and refill bursts
      if (state == sLookup && !anyHit) memReq <= 1'b1;
      else if (lastBeat) memReq <= 1'b0;
      else if (state == sRefill) memReq <= 1'b1;
    end
  end

  // request latch and refill buffer
  always_ff @(posedge clk) begin
    if (state == sIdle && req) begin
      addrR   <= reqAddr;
      byteEnR <= reqByteEn;
      dataR   <= reqData;
    end
    if (state == sRefill && beat) begin
      lineBuf[beatCnt] <= memRdata;
    end
  end

  aOneHit: assert property (
    @(posedge clk) disable iff (rst) $onehot0(hitVec)
  ) else $error("tag matched in more than one way");

  aNoMemInIdle: assert property (
    @(posedge clk) disable iff (rst) !(memReq && state == sIdle)
  ) else $error("memReq left high in idle");

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/icachePkg.sv
src/cacheWay.sv
src/lruAges.sv
src/missControl.sv
src/icacheTop.sv
dv/clkGen.sv
dv/memModel.sv
dv/tbTop.sv
